/* src.f */
verilog/stm_pkg.sv
verilog/sys_time_counter.sv
verilog/sync_idx_gen.sv
verilog/ec_time_to_sys_time.sv
verilog/time_sub.sv
verilog/stm_swapchain.sv
verilog/stm_settings_wb.sv
verilog/stm_top.sv
tests/stm_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= stm_tb
RTL_TOP    ?= stm_top
FILELIST   ?= src.f
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/stm_tb.sv */
`timescale 1ns/10ps

module stm_tb import stm_pkg::*; ();

  localparam int TimeoutCycles = 20000;
  localparam int WaitLimit = 1000;
  localparam logic [1:0] PH_INF = 2'd0;
  localparam logic [1:0] PH_WAIT = 2'd1;
  localparam logic [1:0] PH_RUN = 2'd2;

  logic CLK;
  logic rst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic [3:0] gpio;
  logic stop;
  logic segment;
  idx_t [NumSegment-1:0] idx;

  int mismatches = 0;
  int other_errors = 0;
  int cycles = 0;
  logic [31:0] lfsr;

  // Values the host has written, as seen by the model.
  idx_t [NumSegment-1:0] sh_cyc;
  idx_t [NumSegment-1:0] sh_fd;
  logic upd_tog;
  logic cmd_seg;
  idx_t cmd_rep;
  mode_t cmd_mode;
  sys_time_t cmd_target;
  logic [1:0] cmd_pin;

  // Reference model state.
  sys_time_t m_time;
  idx_t [NumSegment-1:0] m_idx;
  idx_t [NumSegment-1:0] m_idx_d;
  idx_t [NumSegment-1:0] m_div;
  logic [NumSegment-1:0] chg;
  logic [NumSegment-1:0] wrap;
  logic [3:0] g1;
  logic [3:0] g2;
  logic upd_seen;
  logic [1:0] phase;
  logic exp_seg;
  logic exp_stop;
  logic ext_on;
  logic tic_mode;
  idx_t m_tic;
  idx_t loop_cnt;
  logic run_req;
  idx_t run_rep;
  mode_t run_mode;
  sys_time_t run_target;
  logic [1:0] run_pin;
  logic start_cond;
  logic tic_end;
  logic loop_ev;

  stm_top stm_top_inst (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .gpio    (gpio),
    .stop    (stop),
    .segment (segment),
    .idx     (idx)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Sample index per segment, time base and GPIO synchroniser.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      m_time <= '0;
      m_idx <= '0;
      m_idx_d <= '0;
      m_div <= '0;
      g1 <= '0;
      g2 <= '0;
    end else begin
      m_time <= m_time + 1'b1;
      m_idx_d <= m_idx;
      g1 <= gpio;
      g2 <= g1;
      for (int i = 0; i < NumSegment; i++) begin
        if (m_div[i] >= idx_t'(sh_fd[i] - 16'd1)) begin
          m_div[i] <= '0;
          m_idx[i] <= (m_idx[i] == idx_t'(sh_cyc[i] - 16'd1)) ? '0 : idx_t'(m_idx[i] + 16'd1);
        end else begin
          m_div[i] <= idx_t'(m_div[i] + 16'd1);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumSegment; i++) begin
      chg[i] = m_idx[i] != m_idx_d[i];
      wrap[i] = chg[i] && m_idx[i] == '0;
    end
    case (run_mode)
      TRANSITION_MODE_SYNC_IDX: start_cond = wrap[run_req];
      TRANSITION_MODE_SYS_TIME: start_cond = m_time >= run_target + sys_time_t'(Latency);
      TRANSITION_MODE_GPIO: start_cond = chg[run_req] && g2[run_pin];
      default: start_cond = 1'b0;
    endcase
    tic_end = m_tic >= sh_cyc[exp_seg];
    loop_ev = tic_mode ? (chg[exp_seg] && tic_end) : wrap[exp_seg];
  end

  // The expected segment, stop and tic index advance with one decision per edge.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      upd_seen <= 1'b0;
      phase <= PH_INF;
      exp_seg <= 1'b0;
      exp_stop <= 1'b0;
      ext_on <= 1'b0;
      tic_mode <= 1'b0;
      m_tic <= '0;
      loop_cnt <= '0;
      run_req <= 1'b0;
      run_rep <= '0;
      run_mode <= TRANSITION_MODE_SYNC_IDX;
      run_target <= '0;
      run_pin <= '0;
    end else if (upd_tog != upd_seen) begin
      upd_seen <= upd_tog;
      if (cmd_rep == InfiniteRep) begin
        exp_seg <= cmd_seg;
        exp_stop <= 1'b0;
        ext_on <= cmd_mode == TRANSITION_MODE_EXT;
        tic_mode <= 1'b0;
        phase <= PH_INF;
      end else begin
        run_req <= cmd_seg;
        run_rep <= cmd_rep;
        run_mode <= cmd_mode;
        run_target <= cmd_target;
        run_pin <= cmd_pin;
        phase <= PH_WAIT;
      end
    end else begin
      case (phase)
        PH_INF: begin
          if (ext_on && wrap[exp_seg]) begin
            exp_seg <= ~exp_seg;
          end
        end
        PH_WAIT: begin
          if (start_cond) begin
            phase <= PH_RUN;
            exp_seg <= run_req;
            exp_stop <= 1'b0;
            loop_cnt <= '0;
            m_tic <= '0;
            tic_mode <= run_mode != TRANSITION_MODE_SYNC_IDX;
          end
        end
        default: begin
          if (loop_ev) begin
            if (loop_cnt == run_rep) begin
              exp_stop <= 1'b1;
            end else begin
              loop_cnt <= idx_t'(loop_cnt + 16'd1);
            end
          end
          if (tic_mode && chg[exp_seg]) begin
            m_tic <= tic_end ? '0 : idx_t'(m_tic + 16'd1);
          end
        end
      endcase
    end
  end

  a_swap: assert property (@(posedge CLK) disable iff (!rst_n)
    segment == exp_seg && stop == exp_stop)
    else begin
      mismatches++;
      $display("MISMATCH at %0t: segment %0d stop %0d, expected segment %0d stop %0d",
               $time, $sampled(segment), $sampled(stop), $sampled(exp_seg), $sampled(exp_stop));
    end

  a_sync_idx: assert property (@(posedge CLK) disable iff (!rst_n)
    !tic_mode |-> idx == m_idx_d)
    else begin
      mismatches++;
      $display("MISMATCH at %0t: idx %h, expected sync index %h",
               $time, $sampled(idx), $sampled(m_idx_d));
    end

  a_tic_idx: assert property (@(posedge CLK) disable iff (!rst_n)
    tic_mode |-> idx[exp_seg] == m_tic)
    else begin
      mismatches++;
      $display("MISMATCH at %0t: tic index %0d, expected %0d",
               $time, $sampled(idx[exp_seg]), $sampled(m_tic));
    end

  a_ack_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      mismatches++;
      $display("MISMATCH at %0t: ack held for more than one cycle", $time);
    end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Performs one classic cycle and returns at the falling edge after the request is released.
  task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                            output wb_data_t rdat);
    int n;
    n = 0;
    @(posedge CLK);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    @(negedge CLK);
    while (!wb_rsp.ack && n < 16) begin
      @(negedge CLK);
      n++;
    end
    if (!wb_rsp.ack) begin
      other_errors++;
      $display("No ack for the access to register %0d at %0t", adr, $time);
    end
    rdat = wb_rsp.dat;
    if (we) begin
      if (adr == ADDR_CYCLE0) sh_cyc[0] = dat[15:0];
      if (adr == ADDR_CYCLE1) sh_cyc[1] = dat[15:0];
      if (adr == ADDR_FREQ_DIV0) sh_fd[0] = dat[15:0];
      if (adr == ADDR_FREQ_DIV1) sh_fd[1] = dat[15:0];
      if (adr == ADDR_UPDATE) upd_tog = ~upd_tog;
    end
    @(posedge CLK);
    wb_req <= '0;
    @(negedge CLK);
  endtask

  task automatic reg_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic check_read(input wb_addr_t adr, input wb_data_t exp);
    wb_data_t got;
    bus_access(1'b0, adr, '0, got);
    assert (got == exp) else begin
      mismatches++;
      $display("MISMATCH at %0t: register %0d read %h, expected %h", $time, adr, got, exp);
    end
  endtask

  task automatic do_update(input logic seg, input idx_t rep, input mode_t mode,
                           input ec_time_t value);
    reg_write(seg ? ADDR_REP1 : ADDR_REP0, {16'h0, rep});
    reg_write(ADDR_VALUE_LO, value[31:0]);
    reg_write(ADDR_VALUE_HI, value[63:32]);
    reg_write(ADDR_MODE, {23'h0, seg, mode});
    cmd_seg = seg;
    cmd_rep = rep;
    cmd_mode = mode;
    cmd_target = sys_time_t'(value >> EcTimeShift);
    cmd_pin = value[1:0];
    reg_write(ADDR_UPDATE, 32'h1);
  endtask

  // Waits for the requested segment to start and then for stop.
  task automatic run_to_stop(input logic seg);
    int n;
    n = 0;
    while (!(segment == seg && !stop) && n < WaitLimit) begin
      @(negedge CLK);
      n++;
    end
    while (!stop && n < WaitLimit) begin
      @(negedge CLK);
      n++;
    end
    if (!stop) begin
      other_errors++;
      $display("Stop never rose for segment %0d by %0t", seg, $time);
    end
    repeat (20) @(negedge CLK);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] g;
    logic [1:0] pin;
    sys_time_t target;
    rst_n = 1'b0;
    wb_req = '0;
    gpio = '0;
    sh_cyc = '0;
    sh_fd = '0;
    upd_tog = 1'b0;
    cmd_seg = 1'b0;
    cmd_rep = '0;
    cmd_mode = '0;
    cmd_target = '0;
    cmd_pin = '0;
    lfsr = 32'h5d1a_8808;
    repeat (5) @(posedge CLK);
    rst_n <= 1'b1;

    for (int i = 0; i < NumSegment; i++) begin
      rand_bits(2, r);
      reg_write(i == 0 ? ADDR_CYCLE0 : ADDR_CYCLE1, 32'd2 + r);
    end
    for (int i = 0; i < NumSegment; i++) begin
      rand_bits(2, r);
      reg_write(i == 0 ? ADDR_FREQ_DIV0 : ADDR_FREQ_DIV1, 32'd1 + r);
    end

    check_read(ADDR_STATUS, 32'h0);
    reg_write(ADDR_REP0, 32'h0000_1234);
    reg_write(ADDR_REP1, 32'h0000_00A5);
    reg_write(ADDR_MODE, 32'h0000_01F0);
    reg_write(ADDR_VALUE_LO, 32'h8E21_0C37);
    reg_write(ADDR_VALUE_HI, 32'h1B3D_7F40);
    check_read(ADDR_CYCLE0, {16'h0, sh_cyc[0]});
    check_read(ADDR_CYCLE1, {16'h0, sh_cyc[1]});
    check_read(ADDR_FREQ_DIV0, {16'h0, sh_fd[0]});
    check_read(ADDR_FREQ_DIV1, {16'h0, sh_fd[1]});
    check_read(ADDR_REP0, 32'h0000_1234);
    check_read(ADDR_REP1, 32'h0000_00A5);
    check_read(ADDR_MODE, 32'h0000_01F0);
    check_read(ADDR_VALUE_LO, 32'h8E21_0C37);
    check_read(ADDR_VALUE_HI, 32'h1B3D_7F40);

    do_update(1'b1, InfiniteRep, TRANSITION_MODE_SYNC_IDX, '0);
    repeat (50) @(negedge CLK);
    do_update(1'b0, InfiniteRep, TRANSITION_MODE_EXT, '0);
    repeat (80) @(negedge CLK);
    do_update(1'b0, InfiniteRep, TRANSITION_MODE_SYNC_IDX, '0);

    rand_bits(2, r);
    do_update(1'b1, idx_t'(r), TRANSITION_MODE_SYNC_IDX, '0);
    run_to_stop(1'b1);

    rand_bits(2, r);
    target = m_time + sys_time_t'(300);
    do_update(1'b0, idx_t'(r), TRANSITION_MODE_SYS_TIME, ec_time_t'(target) << EcTimeShift);
    run_to_stop(1'b0);

    rand_bits(2, r);
    pin = r[1:0];
    rand_bits(4, g);
    @(posedge CLK);
    gpio <= g[3:0] & ~(4'b0001 << pin);
    rand_bits(2, r);
    do_update(1'b1, idx_t'(r), TRANSITION_MODE_GPIO, ec_time_t'(pin));
    repeat (40) @(negedge CLK);
    @(posedge CLK);
    gpio <= gpio | (4'b0001 << pin);
    run_to_stop(1'b1);

    $display("Errors: mismatches %0d, other %0d", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog/stm_top.sv */
`timescale 1ns/10ps

module stm_top import stm_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  wb_req_t               wb_req,
  output wb_rsp_t               wb_rsp,
  input  logic [3:0]            gpio,
  output logic                  stop,
  output logic                  segment,
  output idx_t [NumSegment-1:0] idx
);

  sys_time_t sys_time;
  stm_settings_t settings;
  logic update_settings;
  idx_t [NumSegment-1:0] sync_idx;
  logic [3:0] gpio_meta;
  logic [3:0] gpio_sync;

  // The GPIO pins are asynchronous to CLK.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= gpio;
      gpio_sync <= gpio_meta;
    end
  end

  sys_time_counter sys_time_counter_inst (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .sys_time (sys_time)
  );

  stm_settings_wb stm_settings_wb_inst (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .wb_req          (wb_req),
    .wb_rsp          (wb_rsp),
    .settings        (settings),
    .update_settings (update_settings),
    .stop            (stop),
    .segment         (segment)
  );

  sync_idx_gen sync_idx_gen_inst (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .sys_time (sys_time),
    .cycle    (settings.cycle),
    .freq_div (settings.freq_div),
    .sync_idx (sync_idx)
  );

  stm_swapchain stm_swapchain_inst (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .sys_time        (sys_time),
    .update_settings (update_settings),
    .settings        (settings),
    .sync_idx        (sync_idx),
    .gpio            (gpio_sync),
    .stop            (stop),
    .segment         (segment),
    .idx             (idx)
  );

endmodule

/* verilog/stm_settings_wb.sv */
`timescale 1ns/10ps

module stm_settings_wb import stm_pkg::*; (
  input  logic          CLK,
  input  logic          rst_n,
  input  wb_req_t       wb_req,
  output wb_rsp_t       wb_rsp,
  output stm_settings_t settings,
  output logic          update_settings,
  input  logic          stop,
  input  logic          segment
);

  logic ack;
  logic access;
  wb_data_t rd_data;
  wb_data_t rd_mux;

  // A new access is accepted only while no ack is pending.
  assign access = wb_req.cyc && wb_req.stb && !ack;

  assign wb_rsp.ack = ack;
  assign wb_rsp.dat = rd_data;

  always_comb begin
    rd_mux = '0;
    case (wb_req.adr)
      ADDR_CYCLE0: rd_mux[15:0] = settings.cycle[0];
      ADDR_CYCLE1: rd_mux[15:0] = settings.cycle[1];
      ADDR_REP0: rd_mux[15:0] = settings.rep[0];
      ADDR_REP1: rd_mux[15:0] = settings.rep[1];
      ADDR_FREQ_DIV0: rd_mux[15:0] = settings.freq_div[0];
      ADDR_FREQ_DIV1: rd_mux[15:0] = settings.freq_div[1];
      ADDR_MODE: rd_mux[8:0] = {settings.req_segment, settings.mode};
      ADDR_VALUE_LO: rd_mux = settings.value[31:0];
      ADDR_VALUE_HI: rd_mux = settings.value[63:32];
      // Status has segment in bit 0 and stop in bit 1.
      ADDR_STATUS: rd_mux[1:0] = {stop, segment};
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
      update_settings <= 1'b0;
      settings <= '0;
      rd_data <= '0;
    end else begin
      ack <= access;
      update_settings <= access && wb_req.we && wb_req.adr == ADDR_UPDATE;
      if (access) begin
        rd_data <= rd_mux;
      end
      if (access && wb_req.we) begin
        case (wb_req.adr)
          ADDR_CYCLE0: settings.cycle[0] <= wb_req.dat[15:0];
          ADDR_CYCLE1: settings.cycle[1] <= wb_req.dat[15:0];
          ADDR_REP0: settings.rep[0] <= wb_req.dat[15:0];
          ADDR_REP1: settings.rep[1] <= wb_req.dat[15:0];
          ADDR_FREQ_DIV0: settings.freq_div[0] <= wb_req.dat[15:0];
          ADDR_FREQ_DIV1: settings.freq_div[1] <= wb_req.dat[15:0];
          ADDR_MODE: begin
            settings.mode <= wb_req.dat[7:0];
            settings.req_segment <= wb_req.dat[8];
          end
          ADDR_VALUE_LO: settings.value[31:0] <= wb_req.dat;
          ADDR_VALUE_HI: settings.value[63:32] <= wb_req.dat;
          default: ;
        endcase
      end
    end
  end

  a_ack_single: assert property (@(posedge CLK) disable iff (!rst_n)
    ack |=> !ack);

endmodule

/* verilog/stm_swapchain.sv */
`timescale 1ns/10ps

module stm_swapchain import stm_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  sys_time_t             sys_time,
  input  logic                  update_settings,
  input  stm_settings_t         settings,
  input  idx_t [NumSegment-1:0] sync_idx,
  input  logic [3:0]            gpio,
  output logic                  stop,
  output logic                  segment,
  output idx_t [NumSegment-1:0] idx
);

  localparam int LatW = $clog2(Latency);

  swap_state_t state;
  idx_mode_t idx_mode;
  logic ext_mode;
  logic req_segment;
  idx_t rep;
  idx_t loop_cnt;
  idx_t [NumSegment-1:0] idx_old;
  idx_t [NumSegment-1:0] tic_idx;
  logic [NumSegment-1:0] idx_changed;
  logic wait_transition;
  logic [LatW-1:0] addsub_latency;
  logic tt_din_valid;
  logic tt_dout_valid;
  sys_time_t transition_time;
  time_diff_t time_diff;
  logic req_wrap;
  logic act_wrap;
  logic tic_wrap;
  logic loop_end;
  logic start;

  ec_time_to_sys_time ec_time_to_sys_time_inst (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .ec_time    (settings.value),
    .din_valid  (tt_din_valid),
    .sys_time   (transition_time),
    .dout_valid (tt_dout_valid)
  );

  time_sub time_sub_inst (
    .CLK   (CLK),
    .rst_n (rst_n),
    .a     (sys_time),
    .b     (transition_time),
    .s     (time_diff)
  );

  for (genvar i = 0; i < NumSegment; i++) begin : gen_seg
    always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
        idx_old[i] <= '0;
      end else begin
        idx_old[i] <= sync_idx[i];
      end
    end

    assign idx_changed[i] = idx_old[i] != sync_idx[i];
    assign idx[i] = (idx_mode == IDX_MODE_SYNC_IDX) ? idx_old[i] : tic_idx[i];

    a_tic_bound: assert property (@(posedge CLK) disable iff (!rst_n)
      state == FINITE_LOOP && idx_mode == IDX_MODE_TIC && segment == 1'(i)
        && $stable(settings.cycle[i]) |-> tic_idx[i] <= settings.cycle[i]);
  end

  // A wrap is the cycle in which an index has just moved back to 0.
  assign req_wrap = idx_changed[req_segment] && sync_idx[req_segment] == '0;
  assign act_wrap = idx_changed[segment] && sync_idx[segment] == '0;
  assign tic_wrap = tic_idx[segment] >= settings.cycle[segment];
  assign loop_end = (idx_mode == IDX_MODE_SYNC_IDX) ? act_wrap :
                    (idx_changed[segment] && tic_wrap);

  always_comb begin
    case (settings.mode)
      TRANSITION_MODE_SYNC_IDX: start = req_wrap;
      TRANSITION_MODE_SYS_TIME: begin
        start = !wait_transition && addsub_latency == LatW'(Latency - 1) && time_diff >= 0;
      end
      TRANSITION_MODE_GPIO: start = idx_changed[req_segment] && gpio[settings.value[1:0]];
      default: start = 1'b0;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= INFINITE_LOOP;
      idx_mode <= IDX_MODE_SYNC_IDX;
      ext_mode <= 1'b0;
      segment <= 1'b0;
      stop <= 1'b0;
      req_segment <= 1'b0;
      rep <= '0;
      loop_cnt <= '0;
      tic_idx <= '0;
      wait_transition <= 1'b0;
      addsub_latency <= '0;
      tt_din_valid <= 1'b0;
    end else if (update_settings) begin
      if (settings.rep[settings.req_segment] == InfiniteRep) begin
        stop <= 1'b0;
        segment <= settings.req_segment;
        idx_mode <= IDX_MODE_SYNC_IDX;
        ext_mode <= settings.mode == TRANSITION_MODE_EXT;
        state <= INFINITE_LOOP;
      end else begin
        rep <= settings.rep[settings.req_segment];
        req_segment <= settings.req_segment;
        tt_din_valid <= settings.mode == TRANSITION_MODE_SYS_TIME;
        wait_transition <= 1'b1;
        addsub_latency <= '0;
        state <= WAIT_START;
      end
    end else begin
      tt_din_valid <= 1'b0;
      case (state)
        WAIT_START: begin
          // The subtractor output is trusted once the converted time has filled it.
          if (wait_transition) begin
            if (tt_dout_valid) begin
              wait_transition <= 1'b0;
            end
          end else if (addsub_latency != LatW'(Latency - 1)) begin
            addsub_latency <= addsub_latency + 1'b1;
          end
          if (start) begin
            stop <= 1'b0;
            loop_cnt <= '0;
            segment <= req_segment;
            state <= FINITE_LOOP;
            if (settings.mode == TRANSITION_MODE_SYNC_IDX) begin
              idx_mode <= IDX_MODE_SYNC_IDX;
            end else begin
              idx_mode <= IDX_MODE_TIC;
              tic_idx[req_segment] <= '0;
            end
          end
        end
        INFINITE_LOOP: begin
          if (ext_mode && act_wrap) begin
            segment <= ~segment;
          end
        end
        FINITE_LOOP: begin
          if (loop_end) begin
            if (loop_cnt == rep) begin
              stop <= 1'b1;
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end
          if (idx_mode == IDX_MODE_TIC && idx_changed[segment]) begin
            tic_idx[segment] <= tic_wrap ? '0 : tic_idx[segment] + 1'b1;
          end
        end
        default: state <= INFINITE_LOOP;
      endcase
    end
  end

  a_stop_in_finite: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(stop) |-> $past(state) == FINITE_LOOP);

  a_segment_change: assert property (@(posedge CLK) disable iff (!rst_n)
    $changed(segment) |-> state == INFINITE_LOOP
      || (state == FINITE_LOOP && $past(state) == WAIT_START));

endmodule

/* verilog/time_sub.sv */
`timescale 1ns/10ps

module time_sub import stm_pkg::*; (
  input  logic       CLK,
  input  logic       rst_n,
  input  sys_time_t  a,
  input  sys_time_t  b,
  output time_diff_t s
);

  localparam int DiffW = $bits(time_diff_t);
  localparam int SliceW = (DiffW + Latency - 1) / Latency;
  localparam int PadW = SliceW * Latency;

  typedef logic [PadW-1:0] pad_t;
  typedef logic [SliceW:0] part_t;

  pad_t a_ext;
  pad_t b_inv;
  pad_t a_pipe [Latency-1];
  pad_t b_pipe [Latency-1];
  logic c_pipe [Latency-1];
  pad_t s_pipe [Latency];
  part_t part [Latency];

  // Both times are unsigned, so they are zero extended.
  // The difference is a plus the inverted b plus one.
  assign a_ext = pad_t'(a);
  assign b_inv = ~pad_t'(b);

  always_comb begin
    part[0] = {1'b0, a_ext[SliceW-1:0]} + {1'b0, b_inv[SliceW-1:0]} + part_t'(1);
    for (int k = 1; k < Latency; k++) begin
      part[k] = {1'b0, a_pipe[k-1][k*SliceW +: SliceW]}
              + {1'b0, b_pipe[k-1][k*SliceW +: SliceW]}
              + part_t'(c_pipe[k-1]);
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < Latency - 1; k++) begin
        a_pipe[k] <= '0;
        b_pipe[k] <= '0;
        c_pipe[k] <= 1'b0;
      end
      for (int k = 0; k < Latency; k++) begin
        s_pipe[k] <= '0;
      end
    end else begin
      a_pipe[0] <= a_ext;
      b_pipe[0] <= b_inv;
      for (int k = 1; k < Latency - 1; k++) begin
        a_pipe[k] <= a_pipe[k-1];
        b_pipe[k] <= b_pipe[k-1];
      end
      for (int k = 0; k < Latency - 1; k++) begin
        c_pipe[k] <= part[k][SliceW];
      end
      s_pipe[0] <= pad_t'(part[0][SliceW-1:0]);
      for (int k = 1; k < Latency; k++) begin
        s_pipe[k] <= s_pipe[k-1];
        s_pipe[k][k*SliceW +: SliceW] <= part[k][SliceW-1:0];
      end
    end
  end

  assign s = time_diff_t'(s_pipe[Latency-1][DiffW-1:0]);

endmodule

/* verilog/ec_time_to_sys_time.sv */
`timescale 1ns/10ps

module ec_time_to_sys_time import stm_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  input  ec_time_t  ec_time,
  input  logic      din_valid,
  output sys_time_t sys_time,
  output logic      dout_valid
);

  ec_time_t ec_time_q;
  logic [EcLatency-1:0] valid_pipe;

  assign dout_valid = valid_pipe[EcLatency-1];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
      ec_time_q <= '0;
      sys_time <= '0;
    end else begin
      valid_pipe <= {valid_pipe[EcLatency-2:0], din_valid};
      ec_time_q <= ec_time;
      // One EC unit is an eighth of a clock, so the low bits drop out.
      sys_time <= sys_time_t'(ec_time_q >> EcTimeShift);
    end
  end

endmodule

/* verilog/sync_idx_gen.sv */
`timescale 1ns/10ps

module sync_idx_gen import stm_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  sys_time_t             sys_time,
  input  idx_t [NumSegment-1:0] cycle,
  input  idx_t [NumSegment-1:0] freq_div,
  output idx_t [NumSegment-1:0] sync_idx
);

  sys_time_t last_time;
  logic tick;

  // The indices only move when the system time has advanced.
  assign tick = sys_time != last_time;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      last_time <= '1;
    end else begin
      last_time <= sys_time;
    end
  end

  for (genvar i = 0; i < NumSegment; i++) begin : gen_seg
    idx_t div_cnt;
    idx_t idx_q;
    idx_t div_last;
    idx_t idx_last;

    assign div_last = freq_div[i] - 1'b1;
    assign idx_last = cycle[i] - 1'b1;
    assign sync_idx[i] = idx_q;

    always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
        div_cnt <= '0;
        idx_q <= '0;
      end else if (idx_q > idx_last) begin
        // A shorter cycle was written while the index was beyond it.
        idx_q <= '0;
      end else if (tick) begin
        if (div_cnt >= div_last) begin
          div_cnt <= '0;
          idx_q <= (idx_q == idx_last) ? '0 : idx_q + 1'b1;
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
      end
    end

    a_idx_in_range: assert property (@(posedge CLK) disable iff (!rst_n)
      $stable(cycle[i]) |-> idx_q <= idx_last);
  end

endmodule

/* verilog/sys_time_counter.sv */
`timescale 1ns/10ps

module sys_time_counter import stm_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  output sys_time_t sys_time
);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sys_time <= '0;
    end else begin
      sys_time <= sys_time + 1'b1;
    end
  end

  // Every consumer relies on exactly one tick per clock.
  a_one_tick: assert property (@(posedge CLK) disable iff (!rst_n)
    $past(rst_n) |-> sys_time == sys_time_t'($past(sys_time) + 1'b1));

endmodule

/* verilog/stm_pkg.sv */
package stm_pkg;

  localparam int NumSegment = 2;
  localparam int Latency = 5;
  localparam int EcTimeShift = 3;
  localparam int EcLatency = 2;

  typedef logic [56:0] sys_time_t;
  typedef logic signed [57:0] time_diff_t;
  typedef logic [15:0] idx_t;
  typedef logic [7:0] mode_t;
  typedef logic [63:0] ec_time_t;
  typedef logic [3:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  localparam mode_t TRANSITION_MODE_SYNC_IDX = 8'h00;
  localparam mode_t TRANSITION_MODE_SYS_TIME = 8'h01;
  localparam mode_t TRANSITION_MODE_GPIO = 8'h02;
  localparam mode_t TRANSITION_MODE_EXT = 8'hF0;

  localparam idx_t InfiniteRep = 16'hFFFF;

  // Word addresses of the settings registers.
  localparam wb_addr_t ADDR_CYCLE0 = 4'd0;
  localparam wb_addr_t ADDR_CYCLE1 = 4'd1;
  localparam wb_addr_t ADDR_REP0 = 4'd2;
  localparam wb_addr_t ADDR_REP1 = 4'd3;
  localparam wb_addr_t ADDR_FREQ_DIV0 = 4'd4;
  localparam wb_addr_t ADDR_FREQ_DIV1 = 4'd5;
  localparam wb_addr_t ADDR_MODE = 4'd6;
  localparam wb_addr_t ADDR_VALUE_LO = 4'd7;
  localparam wb_addr_t ADDR_VALUE_HI = 4'd8;
  localparam wb_addr_t ADDR_UPDATE = 4'd9;
  localparam wb_addr_t ADDR_STATUS = 4'd10;

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } swap_state_t;

  typedef enum logic {
    IDX_MODE_SYNC_IDX,
    IDX_MODE_TIC
  } idx_mode_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  typedef struct packed {
    idx_t [NumSegment-1:0] cycle;
    idx_t [NumSegment-1:0] rep;
    idx_t [NumSegment-1:0] freq_div;
    mode_t                 mode;
    logic                  req_segment;
    ec_time_t              value;
  } stm_settings_t;

endpackage
